// File: all.f
common/cpu_pkg.sv
fetch/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_registers.sv
src/cpu_execute.sv
src/cpu_lsu.sv
src/cpu_top.sv
dv/cpu_props.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

// File: common/cpu_pkg.sv
package cpu_pkg;

	// Basic word and field types
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// Core-wide constants
	localparam word_t RESET_VECTOR = 32'h0000_0000;
	localparam word_t INSTR_BYTES = 32'd4;
	localparam int NUM_REGS = 32;
	localparam logic [3:0] WMASK_ALL = 4'b1111;

	// Major opcodes of the supported subset
	localparam opcode_t OPC_LUI = 7'b0110111;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP = 7'b0110011;
	localparam opcode_t OPC_LOAD = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL = 7'b1101111;

	// funct3 and funct7 encodings
	localparam funct3_t F3_ADD = 3'b000;
	localparam funct3_t F3_SLT = 3'b010;
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_OR = 3'b110;
	localparam funct3_t F3_AND = 3'b111;
	localparam funct3_t F3_WORD = 3'b010;
	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;
	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT = 7'b0100000;

	typedef enum logic [2:0] {
		cls_alu_reg,
		cls_alu_imm,
		cls_lui,
		cls_load,
		cls_store,
		cls_branch,
		cls_jal,
		cls_illegal
	} opclass_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		st_run,
		st_wait_mem,
		st_halted
	} exec_state_t;

endpackage

// File: dv/cpu_checker.sv
module cpu_checker (
	input  logic           i_clock,
	input  logic           i_rst,
	input  logic           i_dbus_request,
	input  logic           i_dbus_rw,
	input  logic           i_dbus_ready,
	input  cpu_pkg::word_t i_dbus_address,
	input  cpu_pkg::word_t i_dbus_wdata,
	input  logic [3:0]     i_dbus_wmask,
	input  logic           i_fault
);

	localparam int MAX_STORES = 16;

	cpu_pkg::word_t exp_addr [MAX_STORES];
	cpu_pkg::word_t exp_data [MAX_STORES];
	int exp_count = 0;
	int seen = 0;
	int value_errors = 0;
	int other_errors = 0;

	task automatic add_expected(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
		if (exp_count < MAX_STORES) begin
			exp_addr[exp_count] = addr;
			exp_data[exp_count] = data;
			exp_count++;
		end else begin
			$display("Expected store list is longer than %0d entries", MAX_STORES);
			other_errors++;
		end
	endtask

	// ====================================================================
	// Data-bus writes, compared on the ready cycle

	always @(posedge i_clock) begin
		if (!i_rst && i_dbus_request && i_dbus_ready && i_dbus_rw) begin
			if (i_fault) begin
				$display("Store to %h seen after the fault at time %0t", i_dbus_address, $time);
				other_errors++;
			end else if (seen >= exp_count) begin
				$display("Unexpected extra store to %h at time %0t", i_dbus_address, $time);
				other_errors++;
			end else begin
				if (i_dbus_address !== exp_addr[seen]) begin
					$display("ERR t=%0t o_dbus_address expected=%h actual=%h",
						$time, exp_addr[seen], i_dbus_address);
					value_errors++;
				end
				if (i_dbus_wdata !== exp_data[seen]) begin
					$display("ERR t=%0t o_dbus_wdata expected=%h actual=%h",
						$time, exp_data[seen], i_dbus_wdata);
					value_errors++;
				end
				if (i_dbus_wmask !== 4'b1111) begin
					$display("ERR t=%0t o_dbus_wmask expected=%h actual=%h",
						$time, 4'b1111, i_dbus_wmask);
					value_errors++;
				end
			end
			seen++;
		end
	end

	// End of run: retired count and missing stores
	task automatic final_check(input cpu_pkg::word_t exp_retired, input cpu_pkg::word_t retired);
		if (retired !== exp_retired) begin
			$display("ERR t=%0t o_retired expected=%h actual=%h", $time, exp_retired, retired);
			value_errors++;
		end
		if (seen < exp_count) begin
			$display("Only %0d of %0d expected stores were seen", seen, exp_count);
			other_errors++;
		end
	endtask

endmodule

// File: dv/cpu_props.sv
module cpu_props (
	input  logic                 i_clock,
	input  logic                 i_rst,
	input  logic                 i_ibus_request,
	input  logic                 i_ibus_ready,
	input  cpu_pkg::word_t       i_ibus_address,
	input  logic                 i_dbus_request,
	input  logic                 i_dbus_rw,
	input  logic                 i_dbus_ready,
	input  cpu_pkg::word_t       i_dbus_address,
	input  cpu_pkg::word_t       i_dbus_wdata,
	input  logic                 i_fault,
	input  cpu_pkg::exec_state_t i_exec_state
);

	// ====================================================================
	// Handshake stability while waiting for ready

	ibus_hold: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_ibus_request && !i_ibus_ready) |=> (i_ibus_request && $stable(i_ibus_address)))
		else $error("ibus request or address changed before ready");

	dbus_hold: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_dbus_request && !i_dbus_ready) |=> (i_dbus_request && $stable(i_dbus_rw)
			&& $stable(i_dbus_address) && $stable(i_dbus_wdata)))
		else $error("dbus request, address or data changed before ready");

	// First cycle out of reset
	reset_quiet: assert property (@(posedge i_clock)
		($past(i_rst) && !i_rst) |-> (!i_ibus_request && !i_dbus_request && !i_fault))
		else $error("bus request or fault active right after reset");

	halted_quiet: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_exec_state == cpu_pkg::st_halted) |-> !i_dbus_request)
		else $error("data request while the core is halted");

endmodule

// File: dv/cpu_testdata.txt
// Words 00-2F program, 30-3F data words placed at byte address 0x40 on,
// 50 retired count, 51 store count, 60 on (address, data) pairs of expected stores
@00
123450B7 // lui  x1, 0x12345
06400113 // addi x2, x0, 100
FF900193 // addi x3, x0, -7
00310233 // add  x4, x2, x3
403102B3 // sub  x5, x2, x3
0021A333 // slt  x6, x3, x2
0020C3B3 // xor  x7, x1, x2
00402023 // sw   x4, 0(x0)
00502223 // sw   x5, 4(x0)
00602423 // sw   x6, 8(x0)
00702623 // sw   x7, 12(x0)
0F01F413 // andi x8, x3, 0xf0
70016493 // ori  x9, x2, 0x700
FFF0C513 // xori x10, x1, -1
0030F5B3 // and  x11, x1, x3
00316633 // or   x12, x2, x3
00802823 // sw   x8, 16(x0)
00902A23 // sw   x9, 20(x0)
00A02C23 // sw   x10, 24(x0)
00B02E23 // sw   x11, 28(x0)
02C02023 // sw   x12, 32(x0)
04002683 // lw   x13, 64(x0)
00568693 // addi x13, x13, 5
02D02223 // sw   x13, 36(x0)
00210463 // beq  x2, x2, +8 taken
02202423 // sw   x2, 40(x0) skipped
00211463 // bne  x2, x2, +8 not taken
02602623 // sw   x6, 44(x0)
00311463 // bne  x2, x3, +8 taken
02202823 // sw   x2, 48(x0) skipped
00310463 // beq  x2, x3, +8 not taken
02902823 // sw   x9, 48(x0)
0080076F // jal  x14, +8
02202A23 // sw   x2, 52(x0) skipped
02E02A23 // sw   x14, 52(x0)
00000000 // illegal
@30
CAFE0001
0BADF00D
@50
00000020
0000000D
@60
00000000 0000005D
00000004 0000006B
00000008 00000001
0000000C 12345064
00000010 000000F0
00000014 00000764
00000018 EDCBAFFF
0000001C 12345000
00000020 FFFFFFFD
00000024 CAFE0006
0000002C 00000001
00000030 00000764
00000034 00000084

// File: dv/tb_cpu.sv
module tb_cpu;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int TD_WORDS = 128;
	localparam int PROG_WORDS = 48;
	localparam int DATA_WORDS = 16;
	localparam int DATA_BASE = 16;
	localparam int TD_DATA = 'h30;
	localparam int TD_COUNTS = 'h50;
	localparam int TD_STORES = 'h60;
	localparam int CYCLES_PER_INSTR = 16;
	localparam int TIMEOUT_MARGIN = 200;
	localparam int CYCLE_LIMIT = PROG_WORDS * CYCLES_PER_INSTR + TIMEOUT_MARGIN;
	localparam int DRAIN_CYCLES = 20;
	localparam logic [31:0] SEED = 32'h59ec3a58;

	logic clock;
	logic rst;
	logic ibus_request;
	logic ibus_ready;
	cpu_pkg::word_t ibus_address;
	cpu_pkg::word_t ibus_rdata;
	logic dbus_request;
	logic dbus_rw;
	logic dbus_ready;
	cpu_pkg::word_t dbus_address;
	cpu_pkg::word_t dbus_rdata;
	cpu_pkg::word_t dbus_wdata;
	logic [3:0] dbus_wmask;
	logic fault;
	cpu_pkg::word_t retired;

	cpu_pkg::word_t imem [IMEM_WORDS];
	cpu_pkg::word_t dmem [DMEM_WORDS];
	cpu_pkg::word_t testdata [TD_WORDS];
	cpu_pkg::word_t exp_retired;
	int ibus_wait;
	int dbus_wait;
	int cycles;
	int errors;

	cpu_top DUT (
		.i_clock(clock),
		.i_rst(rst),
		.o_ibus_request(ibus_request),
		.i_ibus_ready(ibus_ready),
		.o_ibus_address(ibus_address),
		.i_ibus_rdata(ibus_rdata),
		.o_dbus_request(dbus_request),
		.o_dbus_rw(dbus_rw),
		.i_dbus_ready(dbus_ready),
		.o_dbus_address(dbus_address),
		.i_dbus_rdata(dbus_rdata),
		.o_dbus_wdata(dbus_wdata),
		.o_dbus_wmask(dbus_wmask),
		.o_fault(fault),
		.o_retired(retired)
	);

	cpu_checker u_checker (
		.i_clock(clock),
		.i_rst(rst),
		.i_dbus_request(dbus_request),
		.i_dbus_rw(dbus_rw),
		.i_dbus_ready(dbus_ready),
		.i_dbus_address(dbus_address),
		.i_dbus_wdata(dbus_wdata),
		.i_dbus_wmask(dbus_wmask),
		.i_fault(fault)
	);

	bind cpu_top cpu_props u_props (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_ibus_request(o_ibus_request),
		.i_ibus_ready(i_ibus_ready),
		.i_ibus_address(o_ibus_address),
		.i_dbus_request(o_dbus_request),
		.i_dbus_rw(o_dbus_rw),
		.i_dbus_ready(i_dbus_ready),
		.i_dbus_address(o_dbus_address),
		.i_dbus_wdata(o_dbus_wdata),
		.i_fault(o_fault),
		.i_exec_state(u_execute.state)
	);

	always #10 clock = ~clock;

	// ====================================================================
	// Bus memory models, ready after 0 to 3 wait cycles

	always @(negedge clock) begin
		if (rst) begin
			ibus_ready = 1'b0;
			ibus_wait = -1;
		end else if (ibus_ready) begin
			ibus_ready = 1'b0;
			ibus_wait = -1;
		end else if (ibus_request) begin
			if (ibus_wait < 0) begin
				ibus_wait = $urandom % 4;
			end
			if (ibus_wait == 0) begin
				ibus_rdata = imem[ibus_address[7:2]];
				ibus_ready = 1'b1;
			end else begin
				ibus_wait--;
			end
		end
	end

	always @(negedge clock) begin
		if (rst) begin
			dbus_ready = 1'b0;
			dbus_wait = -1;
		end else if (dbus_ready) begin
			dbus_ready = 1'b0;
			dbus_wait = -1;
		end else if (dbus_request) begin
			if (dbus_wait < 0) begin
				dbus_wait = $urandom % 4;
			end
			if (dbus_wait == 0) begin
				if (dbus_rw) begin
					dmem[dbus_address[7:2]] = dbus_wdata;
				end
				dbus_rdata = dmem[dbus_address[7:2]];
				dbus_ready = 1'b1;
			end else begin
				dbus_wait--;
			end
		end
	end

	// Program, data image, counts and the ordered store list
	task automatic load_testdata();
		int num_stores;
		for (int i = 0; i < TD_WORDS; i++) begin
			testdata[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = '0;
			imem[i] = '0;
		end
		$readmemh("dv/cpu_testdata.txt", testdata);
		for (int i = 0; i < PROG_WORDS; i++) begin
			imem[i] = testdata[i];
		end
		for (int i = 0; i < DATA_WORDS; i++) begin
			dmem[DATA_BASE + i] = testdata[TD_DATA + i];
		end
		exp_retired = testdata[TD_COUNTS];
		num_stores = int'(testdata[TD_COUNTS + 1]);
		for (int i = 0; i < num_stores; i++) begin
			u_checker.add_expected(testdata[TD_STORES + 2 * i], testdata[TD_STORES + 2 * i + 1]);
		end
	endtask

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		ibus_ready = 1'b0;
		ibus_rdata = '0;
		dbus_ready = 1'b0;
		dbus_rdata = '0;
		ibus_wait = -1;
		dbus_wait = -1;
		cycles = 0;
		void'($urandom(SEED));
		load_testdata();

		repeat (16) @(negedge clock);
		rst = 1'b0;

		// Run until the illegal word halts the core
		while (!fault && cycles < CYCLE_LIMIT) begin
			@(negedge clock);
			cycles++;
		end

		if (!fault) begin
			$display("Timeout: the core did not fault within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
		end else begin
			// Stray stores after the fault would show up here
			repeat (DRAIN_CYCLES) @(negedge clock);
			u_checker.final_check(exp_retired, retired);
			errors = u_checker.value_errors + u_checker.other_errors;
			$display("Errors: %0d value mismatches, %0d other failures",
				u_checker.value_errors, u_checker.other_errors);
			if (errors == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
		end
		$finish;
	end

endmodule

// File: fetch/cpu_fetch.sv
module cpu_fetch (
	input  logic           i_clock,
	input  logic           i_rst,
	input  logic           i_take,
	input  logic           i_jump,
	input  cpu_pkg::word_t i_jump_pc,
	input  logic           i_ibus_ready,
	input  cpu_pkg::word_t i_ibus_rdata,
	output logic           o_ibus_request,
	output cpu_pkg::word_t o_ibus_address,
	output logic           o_valid,
	output cpu_pkg::word_t o_instr,
	output cpu_pkg::word_t o_pc
);

	cpu_pkg::word_t pc;
	cpu_pkg::word_t req_addr;
	cpu_pkg::word_t buf_instr;
	cpu_pkg::word_t buf_pc;
	logic req;
	logic buf_valid;
	logic bus_done;
	logic issue;

	assign bus_done = req && i_ibus_ready;

	// One request at a time and only when the buffer has room for it
	assign issue = !req && !i_jump && (!buf_valid || i_take);

	// ====================================================================
	// Control state

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			pc <= cpu_pkg::RESET_VECTOR;
			req <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			if (i_jump) begin
				pc <= i_jump_pc;
			end else if (issue) begin
				pc <= pc + cpu_pkg::INSTR_BYTES;
			end

			if (issue) begin
				req <= 1'b1;
			end else if (bus_done) begin
				req <= 1'b0;
			end

			// A redirect never meets an open request since a full buffer blocks issue
			if (i_jump) begin
				buf_valid <= 1'b0;
			end else if (bus_done) begin
				buf_valid <= 1'b1;
			end else if (i_take) begin
				buf_valid <= 1'b0;
			end
		end
	end

	// ====================================================================
	// Address and instruction payload

	always_ff @(posedge i_clock) begin
		if (issue) begin
			req_addr <= pc;
		end
		if (bus_done) begin
			buf_instr <= i_ibus_rdata;
			buf_pc <= req_addr;
		end
	end

	assign o_ibus_request = req;
	assign o_ibus_address = req_addr;
	assign o_valid = buf_valid;
	assign o_instr = buf_instr;
	assign o_pc = buf_pc;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_cpu -o Vtb_cpu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_cpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0

// File: src/cpu_decode.sv
module cpu_decode (
	input  cpu_pkg::word_t    i_instr,
	output cpu_pkg::opclass_t o_class,
	output cpu_pkg::alu_op_t  o_alu_op,
	output cpu_pkg::reg_idx_t o_rs1,
	output cpu_pkg::reg_idx_t o_rs2,
	output cpu_pkg::reg_idx_t o_rd,
	output cpu_pkg::word_t    o_imm,
	output logic              o_branch_ne
);

	cpu_pkg::opcode_t opcode;
	cpu_pkg::funct3_t funct3;
	cpu_pkg::funct7_t funct7;
	cpu_pkg::word_t imm_i;
	cpu_pkg::word_t imm_s;
	cpu_pkg::word_t imm_b;
	cpu_pkg::word_t imm_u;
	cpu_pkg::word_t imm_j;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	assign o_rs1 = i_instr[19:15];
	assign o_rs2 = i_instr[24:20];
	assign o_rd = i_instr[11:7];
	assign o_branch_ne = (funct3 == cpu_pkg::F3_BNE);

	// Immediate formats, all sign extended from bit 31
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'h000};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	always_comb begin
		o_class = cpu_pkg::cls_illegal;
		o_alu_op = cpu_pkg::alu_add;
		o_imm = '0;
		case (opcode)
			cpu_pkg::OPC_OP: begin
				o_class = cpu_pkg::cls_alu_reg;
				if (funct7 == cpu_pkg::F7_ALT && funct3 == cpu_pkg::F3_ADD) begin
					o_alu_op = cpu_pkg::alu_sub;
				end else if (funct7 != cpu_pkg::F7_BASE) begin
					o_class = cpu_pkg::cls_illegal;
				end else begin
					case (funct3)
						cpu_pkg::F3_ADD: o_alu_op = cpu_pkg::alu_add;
						cpu_pkg::F3_SLT: o_alu_op = cpu_pkg::alu_slt;
						cpu_pkg::F3_XOR: o_alu_op = cpu_pkg::alu_xor;
						cpu_pkg::F3_OR: o_alu_op = cpu_pkg::alu_or;
						cpu_pkg::F3_AND: o_alu_op = cpu_pkg::alu_and;
						default: o_class = cpu_pkg::cls_illegal;
					endcase
				end
			end
			cpu_pkg::OPC_OP_IMM: begin
				o_class = cpu_pkg::cls_alu_imm;
				o_imm = imm_i;
				case (funct3)
					cpu_pkg::F3_ADD: o_alu_op = cpu_pkg::alu_add;
					cpu_pkg::F3_XOR: o_alu_op = cpu_pkg::alu_xor;
					cpu_pkg::F3_OR: o_alu_op = cpu_pkg::alu_or;
					cpu_pkg::F3_AND: o_alu_op = cpu_pkg::alu_and;
					default: o_class = cpu_pkg::cls_illegal;
				endcase
			end
			cpu_pkg::OPC_LUI: begin
				o_class = cpu_pkg::cls_lui;
				o_alu_op = cpu_pkg::alu_pass_b;
				o_imm = imm_u;
			end
			cpu_pkg::OPC_LOAD: begin
				o_imm = imm_i;
				if (funct3 == cpu_pkg::F3_WORD) begin
					o_class = cpu_pkg::cls_load;
				end
			end
			cpu_pkg::OPC_STORE: begin
				o_imm = imm_s;
				if (funct3 == cpu_pkg::F3_WORD) begin
					o_class = cpu_pkg::cls_store;
				end
			end
			cpu_pkg::OPC_BRANCH: begin
				o_imm = imm_b;
				if (funct3 == cpu_pkg::F3_BEQ || funct3 == cpu_pkg::F3_BNE) begin
					o_class = cpu_pkg::cls_branch;
				end
			end
			cpu_pkg::OPC_JAL: begin
				o_class = cpu_pkg::cls_jal;
				o_imm = imm_j;
			end
			default: o_class = cpu_pkg::cls_illegal;
		endcase
	end

endmodule

// File: src/cpu_execute.sv
module cpu_execute (
	input  logic              i_clock,
	input  logic              i_rst,
	input  logic              i_valid,
	input  cpu_pkg::word_t    i_pc,
	input  cpu_pkg::opclass_t i_class,
	input  cpu_pkg::alu_op_t  i_alu_op,
	input  cpu_pkg::reg_idx_t i_rd,
	input  cpu_pkg::word_t    i_imm,
	input  logic              i_branch_ne,
	input  cpu_pkg::word_t    i_rs1_data,
	input  cpu_pkg::word_t    i_rs2_data,
	output logic              o_take,
	output logic              o_jump,
	output cpu_pkg::word_t    o_jump_pc,
	output logic              o_we,
	output cpu_pkg::reg_idx_t o_rd,
	output cpu_pkg::word_t    o_wdata,
	output logic              o_mem_start,
	output logic              o_mem_write,
	output cpu_pkg::word_t    o_mem_addr,
	output cpu_pkg::word_t    o_mem_wdata,
	input  logic              i_mem_done,
	input  cpu_pkg::word_t    i_mem_rdata,
	output logic              o_fault,
	output cpu_pkg::word_t    o_retired
);

	cpu_pkg::exec_state_t state;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_result;
	cpu_pkg::word_t link;
	cpu_pkg::word_t retired;
	logic fault;
	logic branch_taken;
	logic is_load;

	// ====================================================================
	// ALU and branch compare

	assign alu_b = (i_class == cpu_pkg::cls_alu_reg) ? i_rs2_data : i_imm;

	always_comb begin
		case (i_alu_op)
			cpu_pkg::alu_sub: alu_result = i_rs1_data - alu_b;
			cpu_pkg::alu_and: alu_result = i_rs1_data & alu_b;
			cpu_pkg::alu_or: alu_result = i_rs1_data | alu_b;
			cpu_pkg::alu_xor: alu_result = i_rs1_data ^ alu_b;
			cpu_pkg::alu_slt: alu_result = {31'd0, $signed(i_rs1_data) < $signed(alu_b)};
			cpu_pkg::alu_pass_b: alu_result = alu_b;
			default: alu_result = i_rs1_data + alu_b;
		endcase
	end

	// BNE inverts the equality result
	assign branch_taken = (i_rs1_data == i_rs2_data) ^ i_branch_ne;
	assign link = i_pc + cpu_pkg::INSTR_BYTES;
	assign is_load = (i_class == cpu_pkg::cls_load);

	assign o_jump_pc = i_pc + i_imm;
	assign o_rd = i_rd;
	assign o_wdata = (i_class == cpu_pkg::cls_jal) ? link :
		is_load ? i_mem_rdata : alu_result;

	// Address is rs1 plus offset from the ALU adder
	assign o_mem_write = (i_class == cpu_pkg::cls_store);
	assign o_mem_addr = alu_result;
	assign o_mem_wdata = i_rs2_data;

	// ====================================================================
	// Issue control

	always_comb begin
		o_take = 1'b0;
		o_jump = 1'b0;
		o_we = 1'b0;
		o_mem_start = 1'b0;
		case (state)
			cpu_pkg::st_run: begin
				if (i_valid) begin
					case (i_class)
						cpu_pkg::cls_alu_reg, cpu_pkg::cls_alu_imm, cpu_pkg::cls_lui: begin
							o_take = 1'b1;
							o_we = 1'b1;
						end
						cpu_pkg::cls_branch: begin
							o_take = 1'b1;
							o_jump = branch_taken;
						end
						cpu_pkg::cls_jal: begin
							o_take = 1'b1;
							o_jump = 1'b1;
							o_we = 1'b1;
						end
						cpu_pkg::cls_load, cpu_pkg::cls_store: o_mem_start = 1'b1;
						default: ;
					endcase
				end
			end
			cpu_pkg::st_wait_mem: begin
				o_take = i_mem_done;
				o_we = i_mem_done && is_load;
			end
			default: ;
		endcase
	end

	// ====================================================================
	// State machine, fault and retired count

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= cpu_pkg::st_run;
			fault <= 1'b0;
			retired <= '0;
		end else begin
			if (o_take) begin
				retired <= retired + 32'd1;
			end
			case (state)
				cpu_pkg::st_run: begin
					if (i_valid && i_class == cpu_pkg::cls_illegal) begin
						state <= cpu_pkg::st_halted;
						fault <= 1'b1;
					end else if (o_mem_start) begin
						state <= cpu_pkg::st_wait_mem;
					end
				end
				cpu_pkg::st_wait_mem: begin
					if (i_mem_done) begin
						state <= cpu_pkg::st_run;
					end
				end
				default: ;
			endcase
		end
	end

	assign o_fault = fault;
	assign o_retired = retired;

endmodule

// File: src/cpu_lsu.sv
module cpu_lsu (
	input  logic           i_clock,
	input  logic           i_rst,
	input  logic           i_start,
	input  logic           i_write,
	input  cpu_pkg::word_t i_addr,
	input  cpu_pkg::word_t i_wdata,
	output logic           o_done,
	output cpu_pkg::word_t o_rdata,
	output logic           o_dbus_request,
	output logic           o_dbus_rw,
	input  logic           i_dbus_ready,
	output cpu_pkg::word_t o_dbus_address,
	input  cpu_pkg::word_t i_dbus_rdata,
	output cpu_pkg::word_t o_dbus_wdata,
	output logic [3:0]     o_dbus_wmask
);

	cpu_pkg::word_t addr;
	cpu_pkg::word_t wdata;
	cpu_pkg::word_t rdata;
	logic req;
	logic rw;
	logic done;
	logic accept;

	// New access is only taken while the bus is idle
	assign accept = i_start && !req;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			req <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= req && i_dbus_ready;
			if (accept) begin
				req <= 1'b1;
			end else if (i_dbus_ready) begin
				req <= 1'b0;
			end
		end
	end

	// Request fields held until ready
	always_ff @(posedge i_clock) begin
		if (accept) begin
			rw <= i_write;
			addr <= i_addr;
			wdata <= i_wdata;
		end
		if (req && i_dbus_ready) begin
			rdata <= i_dbus_rdata;
		end
	end

	assign o_done = done;
	assign o_rdata = rdata;
	assign o_dbus_request = req;
	assign o_dbus_rw = rw;
	assign o_dbus_address = addr;
	assign o_dbus_wdata = wdata;
	assign o_dbus_wmask = cpu_pkg::WMASK_ALL;

endmodule

// File: src/cpu_registers.sv
module cpu_registers (
	input  logic              i_clock,
	input  logic              i_rst,
	input  cpu_pkg::reg_idx_t i_rs1,
	input  cpu_pkg::reg_idx_t i_rs2,
	output cpu_pkg::word_t    o_rs1_data,
	output cpu_pkg::word_t    o_rs2_data,
	input  logic              i_we,
	input  cpu_pkg::reg_idx_t i_rd,
	input  cpu_pkg::word_t    i_wdata
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && i_rd != '0) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// x0 is hardwired to zero
	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: src/cpu_top.sv
module cpu_top (
	input  logic           i_clock,
	input  logic           i_rst,

	// Instruction bus
	output logic           o_ibus_request,
	input  logic           i_ibus_ready,
	output cpu_pkg::word_t o_ibus_address,
	input  cpu_pkg::word_t i_ibus_rdata,

	// Data bus
	output logic           o_dbus_request,
	output logic           o_dbus_rw,
	input  logic           i_dbus_ready,
	output cpu_pkg::word_t o_dbus_address,
	input  cpu_pkg::word_t i_dbus_rdata,
	output cpu_pkg::word_t o_dbus_wdata,
	output logic [3:0]     o_dbus_wmask,

	// Status
	output logic           o_fault,
	output cpu_pkg::word_t o_retired
);

	logic fetch_valid;
	cpu_pkg::word_t fetch_instr;
	cpu_pkg::word_t fetch_pc;

	logic exec_take;
	logic exec_jump;
	cpu_pkg::word_t exec_jump_pc;

	cpu_pkg::opclass_t dec_class;
	cpu_pkg::alu_op_t dec_alu_op;
	cpu_pkg::reg_idx_t dec_rs1;
	cpu_pkg::reg_idx_t dec_rs2;
	cpu_pkg::reg_idx_t dec_rd;
	cpu_pkg::word_t dec_imm;
	logic dec_branch_ne;

	cpu_pkg::word_t rs1_data;
	cpu_pkg::word_t rs2_data;
	logic wb_we;
	cpu_pkg::reg_idx_t wb_rd;
	cpu_pkg::word_t wb_wdata;

	logic mem_start;
	logic mem_write;
	cpu_pkg::word_t mem_addr;
	cpu_pkg::word_t mem_wdata;
	logic mem_done;
	cpu_pkg::word_t mem_rdata;

	// ====================================================================
	// Fetch

	cpu_fetch u_fetch (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_take(exec_take),
		.i_jump(exec_jump),
		.i_jump_pc(exec_jump_pc),
		.i_ibus_ready(i_ibus_ready),
		.i_ibus_rdata(i_ibus_rdata),
		.o_ibus_request(o_ibus_request),
		.o_ibus_address(o_ibus_address),
		.o_valid(fetch_valid),
		.o_instr(fetch_instr),
		.o_pc(fetch_pc)
	);

	// ====================================================================
	// Decode and register file

	cpu_decode u_decode (
		.i_instr(fetch_instr),
		.o_class(dec_class),
		.o_alu_op(dec_alu_op),
		.o_rs1(dec_rs1),
		.o_rs2(dec_rs2),
		.o_rd(dec_rd),
		.o_imm(dec_imm),
		.o_branch_ne(dec_branch_ne)
	);

	cpu_registers u_registers (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_rs1(dec_rs1),
		.i_rs2(dec_rs2),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.i_we(wb_we),
		.i_rd(wb_rd),
		.i_wdata(wb_wdata)
	);

	// ====================================================================
	// Execute

	cpu_execute u_execute (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_valid(fetch_valid),
		.i_pc(fetch_pc),
		.i_class(dec_class),
		.i_alu_op(dec_alu_op),
		.i_rd(dec_rd),
		.i_imm(dec_imm),
		.i_branch_ne(dec_branch_ne),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_take(exec_take),
		.o_jump(exec_jump),
		.o_jump_pc(exec_jump_pc),
		.o_we(wb_we),
		.o_rd(wb_rd),
		.o_wdata(wb_wdata),
		.o_mem_start(mem_start),
		.o_mem_write(mem_write),
		.o_mem_addr(mem_addr),
		.o_mem_wdata(mem_wdata),
		.i_mem_done(mem_done),
		.i_mem_rdata(mem_rdata),
		.o_fault(o_fault),
		.o_retired(o_retired)
	);

	// ====================================================================
	// Load/store unit

	cpu_lsu u_lsu (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_start(mem_start),
		.i_write(mem_write),
		.i_addr(mem_addr),
		.i_wdata(mem_wdata),
		.o_done(mem_done),
		.o_rdata(mem_rdata),
		.o_dbus_request(o_dbus_request),
		.o_dbus_rw(o_dbus_rw),
		.i_dbus_ready(i_dbus_ready),
		.o_dbus_address(o_dbus_address),
		.i_dbus_rdata(i_dbus_rdata),
		.o_dbus_wdata(o_dbus_wdata),
		.o_dbus_wmask(o_dbus_wmask)
	);

endmodule
